// File: include/obi_support_defs.svh
// ------------------------------
// sizing macros for the obi data bus monitor
// attribute FIFO depth, outstanding count width
// and number of attribute bits per request
// ------------------------------

`ifndef OBI_SUPPORT_DEFS_SVH
`define OBI_SUPPORT_DEFS_SVH

// requests that may wait for a response at one time
`define OBI_ATTR_FIFO_DEPTH 4

// width of the outstanding count, holds 0 up to the depth
`define OBI_OUTSTANDING_W 3

// store flag and grant parity error
`define OBI_ATTR_W 2

`endif

// File: verilog/obi_support_pkg.sv
// ------------------------------
// shared types for the obi data bus monitor
// count, attribute and FIFO index vectors
// ------------------------------

`include "obi_support_defs.svh"

package obi_support_pkg;

  // number of address phases still waiting for a response
  typedef logic [`OBI_OUTSTANDING_W-1:0] outstanding_cnt_t;

  // per request attribute word
  // bit 0 is the store flag, bit 1 the grant parity error
  typedef logic [`OBI_ATTR_W-1:0] resp_attr_t;

  localparam int ATTR_STORE_BIT  = 0;
  localparam int ATTR_GNTPAR_BIT = 1;

  // read and write index of the attribute FIFO
  typedef logic [$clog2(`OBI_ATTR_FIFO_DEPTH)-1:0] fifo_ptr_t;

endpackage

// File: verilog/obi_phase_monitor.sv
// ------------------------------
// obi phase monitor
// address phase continuation flag and
// count of outstanding address phases
// ------------------------------

`timescale 1ns/1ps

module obi_phase_monitor (
  input  logic                              in_support_if,
  input  logic                              rst_i,
  input  logic                              data_req_i,
  input  logic                              data_gnt_i,
  input  logic                              data_rvalid_i,
  output logic                              addr_ph_cont_o,
  output obi_support_pkg::outstanding_cnt_t outstanding_o
);

  logic req_q;
  logic gnt_q;
  logic addr_accept;
  obi_support_pkg::outstanding_cnt_t cnt_q;

  // ------------------------------
  // address phase continuation
  // ------------------------------

  always_ff @(posedge in_support_if) begin
    if (rst_i) begin
      req_q <= 1'b0;
      gnt_q <= 1'b0;
    end else begin
      req_q <= data_req_i;
      gnt_q <= data_gnt_i;
    end
  end

  // request still held after a cycle that was not granted
  assign addr_ph_cont_o = data_req_i && req_q && !gnt_q;

  // ------------------------------
  // outstanding count
  // ------------------------------

  assign addr_accept = data_req_i && data_gnt_i;

  // saturates at both ends, accept and response together cancel
  always_ff @(posedge in_support_if) begin
    if (rst_i) begin
      cnt_q <= '0;
    end else if (addr_accept && !data_rvalid_i && (cnt_q != '1)) begin
      cnt_q <= cnt_q + 1'b1;
    end else if (!addr_accept && data_rvalid_i && (cnt_q != '0)) begin
      cnt_q <= cnt_q - 1'b1;
    end
  end

  assign outstanding_o = cnt_q;

endmodule

// File: verilog/gntpar_checker.sv
// ------------------------------
// grant parity checker
// flags a grant equal to its parity and
// remembers it while the request waits
// ------------------------------

`timescale 1ns/1ps

module gntpar_checker (
  input  logic in_support_if,
  input  logic rst_i,
  input  logic data_req_i,
  input  logic data_gnt_i,
  input  logic data_gntpar_i,
  output logic gntpar_err_o
);

  logic par_mismatch;
  logic prev_err_q;

  // parity must always be the inverse of the grant
  assign par_mismatch = (data_gnt_i == data_gntpar_i);

  assign gntpar_err_o = data_req_i && (par_mismatch || prev_err_q);

  // keep the error only while the same request is stalled
  always_ff @(posedge in_support_if) begin
    if (rst_i) begin
      prev_err_q <= 1'b0;
    end else if (data_req_i && !data_gnt_i) begin
      prev_err_q <= gntpar_err_o;
    end else begin
      prev_err_q <= 1'b0;
    end
  end

endmodule

// File: verilog/trap_req_monitor.sv
// ------------------------------
// trap request monitor
// flags a data request issued after a trap
// and before the next retirement
// ------------------------------

`timescale 1ns/1ps

module trap_req_monitor (
  input  logic in_support_if,
  input  logic rst_i,
  input  logic data_req_i,
  input  logic data_gnt_i,
  input  logic trap_i,
  input  logic retire_i,
  output logic req_after_trap_o
);

  logic gnt_q;
  logic trap_active_q;
  logic flag_q;

  always_ff @(posedge in_support_if) begin
    if (rst_i) begin
      gnt_q         <= 1'b0;
      trap_active_q <= 1'b0;
      flag_q        <= 1'b0;
    end else begin
      gnt_q <= data_gnt_i;

      // a trap wins over a retirement in the same cycle
      if (trap_i) begin
        trap_active_q <= 1'b1;
        if (data_req_i && gnt_q) begin
          flag_q <= 1'b1;
        end
      end else if (retire_i) begin
        trap_active_q <= 1'b0;
        flag_q        <= 1'b0;
      end else if (trap_active_q && gnt_q && data_req_i) begin
        flag_q <= 1'b1;
      end
    end
  end

  assign req_after_trap_o = flag_q;

endmodule

// File: verilog/resp_attr_fifo.sv
// ------------------------------
// response attribute FIFO
// queues store flag and grant parity error per
// accepted request, presents them with the response
// ------------------------------

`timescale 1ns/1ps

`include "obi_support_defs.svh"

module resp_attr_fifo #(
  parameter int DEPTH = `OBI_ATTR_FIFO_DEPTH
) (
  input  logic in_support_if,
  input  logic rst_i,
  input  logic data_req_i,
  input  logic data_gnt_i,
  input  logic data_rvalid_i,
  input  logic req_is_store_i,
  input  logic gntpar_err_i,
  output logic resp_was_store_o,
  output logic resp_gntpar_err_o,
  output logic full_o,
  output logic empty_o
);

  localparam int CNT_W = $clog2(DEPTH + 1);

  obi_support_pkg::resp_attr_t mem_q [DEPTH];
  obi_support_pkg::resp_attr_t push_attr;
  obi_support_pkg::resp_attr_t head_attr;
  obi_support_pkg::fifo_ptr_t  wr_ptr_q;
  obi_support_pkg::fifo_ptr_t  rd_ptr_q;
  logic [CNT_W-1:0]            count_q;
  logic                        push;
  logic                        pop;

  assign full_o  = (count_q == CNT_W'(DEPTH));
  assign empty_o = (count_q == '0);

  // a push while full is dropped
  assign push = data_req_i && data_gnt_i && !full_o;
  assign pop  = data_rvalid_i && !empty_o;

  always_comb begin
    push_attr = '0;
    push_attr[obi_support_pkg::ATTR_STORE_BIT]  = req_is_store_i;
    push_attr[obi_support_pkg::ATTR_GNTPAR_BIT] = gntpar_err_i;
  end

  // ------------------------------
  // storage and pointers
  // ------------------------------

  always_ff @(posedge in_support_if) begin
    if (push) begin
      mem_q[wr_ptr_q] <= push_attr;
    end
  end

  always_ff @(posedge in_support_if) begin
    if (rst_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (push) begin
        wr_ptr_q <= (wr_ptr_q == obi_support_pkg::fifo_ptr_t'(DEPTH - 1)) ? '0 : wr_ptr_q + 1'b1;
      end
      if (pop) begin
        rd_ptr_q <= (rd_ptr_q == obi_support_pkg::fifo_ptr_t'(DEPTH - 1)) ? '0 : rd_ptr_q + 1'b1;
      end
      if (push && !pop) begin
        count_q <= count_q + 1'b1;
      end else if (!push && pop) begin
        count_q <= count_q - 1'b1;
      end
    end
  end

  // head is read combinationally, zero outside a response
  assign head_attr         = mem_q[rd_ptr_q];
  assign resp_was_store_o  = pop && head_attr[obi_support_pkg::ATTR_STORE_BIT];
  assign resp_gntpar_err_o = pop && head_attr[obi_support_pkg::ATTR_GNTPAR_BIT];

endmodule

// File: verilog/obi_support_top.sv
// ------------------------------
// obi data bus support monitor, top level
// phase monitor, grant parity checker,
// trap monitor and response attribute FIFO
// ------------------------------

`timescale 1ns/1ps

module obi_support_top (
  input  logic                              in_support_if,
  input  logic                              rst_i,
  input  logic                              data_req_i,
  input  logic                              data_gnt_i,
  input  logic                              data_gntpar_i,
  input  logic                              data_rvalid_i,
  input  logic                              req_is_store_i,
  input  logic                              trap_i,
  input  logic                              retire_i,
  output logic                              addr_ph_cont_o,
  output obi_support_pkg::outstanding_cnt_t outstanding_o,
  output logic                              resp_was_store_o,
  output logic                              resp_gntpar_err_o,
  output logic                              req_after_trap_o
);

  logic gntpar_err;
  // FIFO status, watched by the bound assertions
  logic fifo_full;
  logic fifo_empty;

  obi_phase_monitor phase_mon_i (
    .in_support_if  (in_support_if),
    .rst_i          (rst_i),
    .data_req_i     (data_req_i),
    .data_gnt_i     (data_gnt_i),
    .data_rvalid_i  (data_rvalid_i),
    .addr_ph_cont_o (addr_ph_cont_o),
    .outstanding_o  (outstanding_o)
  );

  gntpar_checker gntpar_chk_i (
    .in_support_if (in_support_if),
    .rst_i         (rst_i),
    .data_req_i    (data_req_i),
    .data_gnt_i    (data_gnt_i),
    .data_gntpar_i (data_gntpar_i),
    .gntpar_err_o  (gntpar_err)
  );

  trap_req_monitor trap_mon_i (
    .in_support_if    (in_support_if),
    .rst_i            (rst_i),
    .data_req_i       (data_req_i),
    .data_gnt_i       (data_gnt_i),
    .trap_i           (trap_i),
    .retire_i         (retire_i),
    .req_after_trap_o (req_after_trap_o)
  );

  resp_attr_fifo attr_fifo_i (
    .in_support_if     (in_support_if),
    .rst_i             (rst_i),
    .data_req_i        (data_req_i),
    .data_gnt_i        (data_gnt_i),
    .data_rvalid_i     (data_rvalid_i),
    .req_is_store_i    (req_is_store_i),
    .gntpar_err_i      (gntpar_err),
    .resp_was_store_o  (resp_was_store_o),
    .resp_gntpar_err_o (resp_gntpar_err_o),
    .full_o            (fifo_full),
    .empty_o           (fifo_empty)
  );

endmodule

// File: bench/tb_clk_gen.sv
// ------------------------------
// testbench clock and reset generator
// ------------------------------

`timescale 1ns/1ps

module tb_clk_gen #(
  parameter int PERIOD_NS = 10,
  parameter int RESET_CYCLES = 2
) (
  output logic clk_o,
  output logic rst_o
);

  initial begin
    clk_o = 1'b0;
    forever #(PERIOD_NS / 2) clk_o = ~clk_o;
  end

  // reset released on a falling edge, away from the sampling edge
  initial begin
    rst_o = 1'b1;
    repeat (RESET_CYCLES) @(posedge clk_o);
    @(negedge clk_o);
    rst_o = 1'b0;
  end

endmodule

// File: bench/obi_support_props.sv
// ------------------------------
// concurrent assertions for the obi support top level
// FIFO overflow and underflow, attribute gating
// ------------------------------

`timescale 1ns/1ps

module obi_support_props (
  input logic in_support_if,
  input logic rst_i,
  input logic data_req_i,
  input logic data_gnt_i,
  input logic data_rvalid_i,
  input logic fifo_full_i,
  input logic fifo_empty_i,
  input logic resp_was_store_i,
  input logic resp_gntpar_err_i
);

  // no accepted address phase while the FIFO is full
  a_no_push_full : assert property (@(posedge in_support_if) disable iff (rst_i)
    (data_req_i && data_gnt_i) |-> !fifo_full_i)
    else $error("address phase accepted with the attribute FIFO full");

  // every response needs a queued request
  a_no_resp_empty : assert property (@(posedge in_support_if) disable iff (rst_i)
    data_rvalid_i |-> !fifo_empty_i)
    else $error("response arrived with the attribute FIFO empty");

  a_attr_gated : assert property (@(posedge in_support_if) disable iff (rst_i)
    !data_rvalid_i |-> (!resp_was_store_i && !resp_gntpar_err_i))
    else $error("response attributes high without rvalid");

endmodule

bind obi_support_top obi_support_props props_i (
  .in_support_if     (in_support_if),
  .rst_i             (rst_i),
  .data_req_i        (data_req_i),
  .data_gnt_i        (data_gnt_i),
  .data_rvalid_i     (data_rvalid_i),
  .fifo_full_i       (fifo_full),
  .fifo_empty_i      (fifo_empty),
  .resp_was_store_i  (resp_was_store_o),
  .resp_gntpar_err_i (resp_gntpar_err_o)
);

// File: bench/obi_support_tb.sv
// ------------------------------
// testbench for the obi data bus support monitor
// random bus stimulus, reference model,
// per cycle comparison, watchdog and report
// ------------------------------

`timescale 1ns/1ps

`include "obi_support_defs.svh"

module obi_support_tb;

  localparam int CLK_PERIOD  = 10;
  localparam int RESET_TEST  = 10;
  localparam int RANDOM_TEST = 300;
  localparam int B2B_TEST    = 60;
  localparam int TRAP_TEST   = 40;
  localparam int DRAIN_MAX   = 30;
  localparam int TEST_CYCLES = RESET_TEST + RANDOM_TEST + B2B_TEST + TRAP_TEST + 3 * DRAIN_MAX;

  logic clk;
  logic rst;
  logic data_req;
  logic data_gnt;
  logic data_gntpar;
  logic data_rvalid;
  logic req_is_store;
  logic trap;
  logic retire;
  logic addr_ph_cont;
  logic resp_was_store;
  logic resp_gntpar_err;
  logic req_after_trap;
  obi_support_pkg::outstanding_cnt_t outstanding;

  // ------------------------------
  // reference model state
  // ------------------------------
  logic m_req_q;
  logic m_gnt_q;
  logic m_prev_err;
  logic m_trap_active;
  logic m_flag;
  obi_support_pkg::outstanding_cnt_t m_cnt;
  obi_support_pkg::resp_attr_t m_attr_q[$];

  // bench side bus bookkeeping
  int    in_flight;
  logic  req_held;
  int    err_cnt;
  int    test_err;
  int    check_cnt;
  int    test_cnt;
  int    flag_seen;
  int    unsigned seed_val;
  string test_name;
  logic [6:0] exp_vec;

  tb_clk_gen #(.PERIOD_NS(CLK_PERIOD), .RESET_CYCLES(2)) clk_gen_i (
    .clk_o (clk),
    .rst_o (rst)
  );

  obi_support_top dut_i (
    .in_support_if     (clk),
    .rst_i             (rst),
    .data_req_i        (data_req),
    .data_gnt_i        (data_gnt),
    .data_gntpar_i     (data_gntpar),
    .data_rvalid_i     (data_rvalid),
    .req_is_store_i    (req_is_store),
    .trap_i            (trap),
    .retire_i          (retire),
    .addr_ph_cont_o    (addr_ph_cont),
    .outstanding_o     (outstanding),
    .resp_was_store_o  (resp_was_store),
    .resp_gntpar_err_o (resp_gntpar_err),
    .req_after_trap_o  (req_after_trap)
  );

  // expected {cont, count, store, gntpar error, trap flag} for this cycle
  function automatic logic [6:0] predict_outputs();
    logic cont;
    logic store;
    logic gperr;
    obi_support_pkg::resp_attr_t head;
    cont  = data_req && m_req_q && !m_gnt_q;
    head  = (m_attr_q.size() > 0) ? m_attr_q[0] : '0;
    store = data_rvalid && head[0];
    gperr = data_rvalid && head[1];
    return {cont, m_cnt, store, gperr, m_flag};
  endfunction

  task automatic reset_model();
    m_req_q       = 1'b0;
    m_gnt_q       = 1'b0;
    m_prev_err    = 1'b0;
    m_trap_active = 1'b0;
    m_flag        = 1'b0;
    m_cnt         = '0;
    m_attr_q.delete();
  endtask

  task automatic advance_model();
    logic accept;
    logic gperr_now;
    accept    = data_req && data_gnt;
    gperr_now = data_req && ((data_gnt == data_gntpar) || m_prev_err);
    if (data_rvalid && m_attr_q.size() > 0) begin
      void'(m_attr_q.pop_front());
    end
    if (accept) begin
      m_attr_q.push_back({gperr_now, req_is_store});
    end
    if (accept && !data_rvalid && m_cnt != '1) begin
      m_cnt = m_cnt + 1'b1;
    end else if (!accept && data_rvalid && m_cnt != '0) begin
      m_cnt = m_cnt - 1'b1;
    end
    // trap takes priority over retire
    if (trap) begin
      m_trap_active = 1'b1;
      if (data_req && m_gnt_q) begin
        m_flag = 1'b1;
      end
    end else if (retire) begin
      m_trap_active = 1'b0;
      m_flag        = 1'b0;
    end else if (m_trap_active && m_gnt_q && data_req) begin
      m_flag = 1'b1;
    end
    m_prev_err = (data_req && !data_gnt) ? gperr_now : 1'b0;
    m_req_q    = data_req;
    m_gnt_q    = data_gnt;
  endtask

  task automatic compare_value(input string sig, input int exp_v, input int act_v);
    check_cnt++;
    if (exp_v != act_v) begin
      $display("[FAIL] %s: %s expected %0d actual %0d", test_name, sig, exp_v, act_v);
      err_cnt++;
      test_err++;
    end
  endtask

  // comparison on every rising edge ahead of the register updates
  always @(posedge clk) begin
    if (rst) begin
      reset_model();
    end else begin
      exp_vec = predict_outputs();
      compare_value("addr_ph_cont_o", int'(exp_vec[6]), int'(addr_ph_cont));
      compare_value("outstanding_o", int'(exp_vec[5:3]), int'(outstanding));
      compare_value("resp_was_store_o", int'(exp_vec[2]), int'(resp_was_store));
      compare_value("resp_gntpar_err_o", int'(exp_vec[1]), int'(resp_gntpar_err));
      compare_value("req_after_trap_o", int'(exp_vec[0]), int'(req_after_trap));
      if (exp_vec[0]) begin
        flag_seen++;
      end
      advance_model();
    end
  end

  // one bus cycle driven on the falling edge
  task automatic drive_bus_cycle(input bit allow_new, input int gnt_pct, input int rv_pct,
                                 input int err_pct, input bit trap_v, input bit retire_v);
    @(negedge clk);
    if (!req_held) begin
      data_req     = allow_new && ($urandom() % 100 < 70);
      req_is_store = ($urandom() % 2) == 1;
    end
    data_gnt    = data_req && (in_flight < `OBI_ATTR_FIFO_DEPTH) && ($urandom() % 100 < gnt_pct);
    data_gntpar = ($urandom() % 100 < err_pct) ? data_gnt : !data_gnt;
    data_rvalid = (in_flight > 0) && ($urandom() % 100 < rv_pct);
    trap        = trap_v;
    retire      = retire_v;
    in_flight   = in_flight + int'(data_req && data_gnt) - int'(data_rvalid);
    req_held    = data_req && !data_gnt;
  endtask

  task automatic drain_bus();
    int n;
    n = 0;
    while ((in_flight > 0 || req_held) && n < DRAIN_MAX) begin
      drive_bus_cycle(1'b0, 100, 100, 0, 1'b0, 1'b0);
      n++;
    end
    drive_bus_cycle(1'b0, 0, 0, 0, 1'b0, 1'b0);
  endtask

  task automatic start_test(input string name);
    test_name = name;
    test_err  = 0;
    test_cnt++;
  endtask

  task automatic finish_test();
    $display("test %s done, %0d mismatches", test_name, test_err);
  endtask

  initial begin
    seed_val     = $urandom(32'hb39ef02e);
    data_req     = 1'b0;
    data_gnt     = 1'b0;
    data_gntpar  = 1'b1;
    data_rvalid  = 1'b0;
    req_is_store = 1'b0;
    trap         = 1'b0;
    retire       = 1'b0;
    in_flight    = 0;
    req_held     = 1'b0;
    err_cnt      = 0;
    check_cnt    = 0;
    test_cnt     = 0;
    flag_seen    = 0;
    test_name    = "reset_values";
    reset_model();

    start_test("reset_values");
    wait (!rst);
    @(negedge clk);
    if (outstanding !== '0 || req_after_trap !== 1'b0) begin
      $display("[FAIL] reset_values: outputs expected 0 actual %0d/%0d",
               outstanding, req_after_trap);
      err_cnt++;
      test_err++;
    end
    repeat (RESET_TEST) drive_bus_cycle(1'b0, 0, 0, 0, 1'b0, 1'b0);
    finish_test();

    // stalls, parity errors and several outstanding responses
    start_test("random_bus");
    repeat (RANDOM_TEST) drive_bus_cycle(1'b1, 50, 40, 15, 1'b0, 1'b0);
    drain_bus();
    finish_test();

    start_test("back_to_back");
    repeat (B2B_TEST) drive_bus_cycle(1'b1, 95, 30, 10, 1'b0, 1'b0);
    drain_bus();
    finish_test();

    // trap pulses, retires and a trap coinciding with a retire
    start_test("trap_retire");
    flag_seen = 0;
    for (int i = 0; i < TRAP_TEST; i++) begin
      drive_bus_cycle(1'b1, 70, 50, 0, (i == 5) || (i == 24) || (i == 33),
                      (i == 15) || (i == 30) || (i == 33));
    end
    drain_bus();
    if (flag_seen == 0) begin
      $display("trap_retire: the trap flag was never expected high, no coverage of the flag");
      err_cnt++;
      test_err++;
    end
    finish_test();

    repeat (2) @(negedge clk);
    $display("tests %0d, checks %0d, errors %0d", test_cnt, check_cnt, err_cnt);
    if (err_cnt == 0) begin
      $display("TB PASSED");
    end else begin
      $display("TB FAILED");
    end
    $finish;
  end

  // watchdog sized from the test lengths
  initial begin
    #(TEST_CYCLES * 2 * CLK_PERIOD);
    $display("timeout: tests did not finish within %0d cycles", TEST_CYCLES * 2);
    $display("TB FAILED");
    $finish;
  end

endmodule

// File: all.f
+incdir+include
verilog/obi_support_pkg.sv
verilog/obi_phase_monitor.sv
verilog/gntpar_checker.sv
verilog/trap_req_monitor.sv
verilog/resp_attr_fifo.sv
verilog/obi_support_top.sv
bench/tb_clk_gen.sv
bench/obi_support_props.sv
bench/obi_support_tb.sv

// File: run.sh
#!/usr/bin/env bash
# build and run the obi support monitor testbench with Verilator
set -e
set -o pipefail

cd "$(dirname "$0")"

verilator --binary --timing --assert \
  -f all.f \
  --top-module obi_support_tb \
  -o sim_obi_support

./obj_dir/sim_obi_support | tee sim.log

if grep -q "TB FAILED" sim.log; then
  exit 1
fi
if ! grep -q "TB PASSED" sim.log; then
  exit 1
fi
exit 0
